/* verilog/memBusPkg.sv */
package memBusPkg;

    // requester command code, same encoding as the CPU side of the tile
    typedef enum logic [1:0] {
        OpIdle  = 2'b00,
        OpWrite = 2'b01,
        OpRead  = 2'b10
    } reqOp_e;

    // one request from the requester, also forwarded by the router
    typedef struct packed {
        reqOp_e      op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  sel;
    } memReq_t;

    // wishbone classic master-to-slave signals
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wbReq_t;

    // wishbone slave-to-master signals
    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] dat;
    } wbRsp_t;

    // control register window, one word per register
    localparam logic [31:0] RegBase = 32'hFFFF_0000;
    localparam int RegCount = 8;

    // byte span of one decoder slot; slot k starts at k * SlotSpan
    localparam logic [31:0] SlotSpan = 32'h0000_1000;

endpackage

/* verilog/wbSram.sv */
`timescale 1ns/1ps

module wbSram #(
    parameter int SramWords = 256
) (
    input  logic               clk,
    input  logic               reset_i,
    input  memBusPkg::wbReq_t  wb_i,
    output memBusPkg::wbRsp_t  wb_o
);

    localparam int AddrBits = (SramWords > 1) ? $clog2(SramWords) : 1;

    logic [31:0] mem [SramWords];
    logic [31:0] wordAddr;
    logic [AddrBits-1:0] wordIdx;
    logic [31:0] rdataQ;
    logic ackQ;
    logic access;

    // word address wraps inside the bank
    assign wordAddr = (wb_i.adr >> 2) % 32'(SramWords);
    assign wordIdx  = wordAddr[AddrBits-1:0];

    // ack low gates out the second cycle of stb, one access per bus cycle
    assign access = wb_i.cyc && wb_i.stb && !ackQ;

    always_ff @(posedge clk) begin
        if (access && wb_i.we) begin
            mem[wordIdx] <= wb_i.dat;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !wb_i.we) begin
            rdataQ <= mem[wordIdx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ackQ <= 1'b0;
        end else begin
            ackQ <= access;
        end
    end

    assign wb_o.ack = ackQ;
    assign wb_o.err = 1'b0;
    assign wb_o.dat = rdataQ;

endmodule

/* verilog/wbDecoder.sv */
`timescale 1ns/1ps

module wbDecoder #(
    parameter int NumSlots = 2
) (
    input  logic                               clk,
    input  logic                               reset_i,
    input  memBusPkg::wbReq_t                  wb_i,
    output memBusPkg::wbRsp_t                  wb_o,
    output memBusPkg::wbReq_t [NumSlots-1:0]   slotReq_o,
    input  memBusPkg::wbRsp_t [NumSlots-1:0]   slotRsp_i
);

    logic [31:0] slotIdx;
    logic unmapped;
    logic errQ;
    memBusPkg::wbRsp_t rspSel;

    assign slotIdx  = wb_i.adr / memBusPkg::SlotSpan;
    assign unmapped = (slotIdx >= 32'(NumSlots));

    // every slot sees the payload, only the addressed one sees cyc and stb
    always_comb begin
        for (int k = 0; k < NumSlots; k++) begin
            slotReq_o[k]     = wb_i;
            slotReq_o[k].cyc = wb_i.cyc && (slotIdx == 32'(k));
            slotReq_o[k].stb = wb_i.stb && (slotIdx == 32'(k));
        end
    end

    // no slot answers an unmapped address, so raise err here for one cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            errQ <= 1'b0;
        end else begin
            errQ <= wb_i.cyc && wb_i.stb && unmapped && !errQ;
        end
    end

    always_comb begin
        rspSel = '0;
        for (int k = 0; k < NumSlots; k++) begin
            if (slotIdx == 32'(k)) begin
                rspSel = slotRsp_i[k];
            end
        end
    end

    // rspSel is all zero when unmapped, so the error carries zero data
    always_comb begin
        wb_o     = rspSel;
        wb_o.err = rspSel.err || errQ;
    end

endmodule

/* verilog/wbManager.sv */
`timescale 1ns/1ps

module wbManager (
    input  logic                clk,
    input  logic                reset_i,
    input  memBusPkg::memReq_t  fwd_i,
    input  logic                fwdValid_i,
    output memBusPkg::wbReq_t   wb_o,
    input  memBusPkg::wbRsp_t   wb_i,
    output logic                mgrDone_o,
    output memBusPkg::wbRsp_t   mgrRsp_o
);

    typedef enum logic [1:0] {
        Idle,
        Cycle,
        Done
    } mgrState_e;

    mgrState_e state;

    // cycle payload, captured when the router hands a request over
    logic [31:0] adrQ;
    logic [31:0] datQ;
    logic [3:0]  selQ;
    logic        weQ;

    // slave response captured at the terminating edge
    memBusPkg::wbRsp_t rspQ;

    logic terminate;

    assign terminate = wb_i.ack || wb_i.err;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: begin
                    if (fwdValid_i) begin
                        state <= Cycle;
                    end
                end
                Cycle: begin
                    // cyc and stb stay up until the slave ends the cycle
                    if (terminate) begin
                        state <= Done;
                    end
                end
                Done: begin
                    state <= Idle;
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle && fwdValid_i) begin
            adrQ <= fwd_i.addr;
            datQ <= fwd_i.wdata;
            selQ <= fwd_i.sel;
            weQ  <= (fwd_i.op == memBusPkg::OpWrite);
        end
    end

    always_ff @(posedge clk) begin
        if (state == Cycle && terminate) begin
            rspQ <= wb_i;
        end
    end

    always_comb begin
        wb_o.cyc = (state == Cycle);
        wb_o.stb = (state == Cycle);
        wb_o.we  = weQ;
        wb_o.adr = adrQ;
        wb_o.dat = datQ;
        wb_o.sel = selQ;
    end

    // one-cycle done pulse, the cycle has already been dropped here
    assign mgrDone_o = (state == Done);
    assign mgrRsp_o  = rspQ;

endmodule

/* verilog/mmioRouter.sv */
`timescale 1ns/1ps

module mmioRouter (
    input  logic                clk,
    input  logic                reset_i,
    input  memBusPkg::memReq_t  req_i,
    output logic                busy_o,
    output logic                done_o,
    output logic [31:0]         rdata_o,
    output logic                busErr_o,
    output memBusPkg::memReq_t  fwd_o,
    output logic                fwdValid_o,
    input  logic                mgrDone_i,
    input  memBusPkg::wbRsp_t   mgrRsp_i
);

    localparam int RegIdxBits = $clog2(memBusPkg::RegCount);

    typedef enum logic [1:0] {
        Idle,
        RegAccess,
        WaitBus
    } routerState_e;

    routerState_e state;
    memBusPkg::memReq_t reqQ;
    logic [31:0] ctrlRegs [memBusPkg::RegCount];
    logic [RegIdxBits-1:0] regIdx;
    logic accept;
    logic inWindow;

    // busy also covers the done cycle, so no new request lands on it
    assign busy_o = (state != Idle) || done_o;
    assign accept = (req_i.op != memBusPkg::OpIdle) && !busy_o;

    assign inWindow = (req_i.addr >= memBusPkg::RegBase) &&
                      ((req_i.addr - memBusPkg::RegBase) < 32'(4 * memBusPkg::RegCount));

    // low two address bits are dropped, a misaligned access hits its word
    assign regIdx = reqQ.addr[RegIdxBits+1:2];

    assign fwd_o = reqQ;

    always_ff @(posedge clk) begin
        if (accept) begin
            reqQ <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= Idle;
            done_o     <= 1'b0;
            rdata_o    <= '0;
            busErr_o   <= 1'b0;
            fwdValid_o <= 1'b0;
        end else begin
            done_o     <= 1'b0;
            fwdValid_o <= 1'b0;
            case (state)
                Idle: begin
                    if (accept) begin
                        state      <= inWindow ? RegAccess : WaitBus;
                        fwdValid_o <= !inWindow;
                    end
                end
                RegAccess: begin
                    done_o   <= 1'b1;
                    busErr_o <= 1'b0;
                    rdata_o  <= (reqQ.op == memBusPkg::OpRead) ? ctrlRegs[regIdx] : '0;
                    state    <= Idle;
                end
                WaitBus: begin
                    // manager result becomes visible one cycle after its pulse
                    if (mgrDone_i) begin
                        done_o   <= 1'b1;
                        busErr_o <= mgrRsp_i.err;
                        rdata_o  <= (reqQ.op == memBusPkg::OpRead) ? mgrRsp_i.dat : '0;
                        state    <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int k = 0; k < memBusPkg::RegCount; k++) begin
                ctrlRegs[k] <= '0;
            end
        end else if (state == RegAccess && reqQ.op == memBusPkg::OpWrite) begin
            ctrlRegs[regIdx] <= reqQ.wdata;
        end
    end

endmodule

/* verilog/memSubsysTop.sv */
`timescale 1ns/1ps

module memSubsysTop #(
    parameter int NumSlots  = 2,
    parameter int SramWords = 256
) (
    input  logic                clk,
    input  logic                reset_i,
    input  memBusPkg::memReq_t  req_i,
    output logic                busy_o,
    output logic                done_o,
    output logic [31:0]         rdata_o,
    output logic                busErr_o
);

    // router to manager
    memBusPkg::memReq_t fwd;
    logic fwdValid;
    logic mgrDone;
    memBusPkg::wbRsp_t mgrRsp;

    // manager to decoder
    memBusPkg::wbReq_t busReq;
    memBusPkg::wbRsp_t busRsp;

    // decoder to banks
    memBusPkg::wbReq_t [NumSlots-1:0] slotReq;
    memBusPkg::wbRsp_t [NumSlots-1:0] slotRsp;

    mmioRouter router_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .req_i      (req_i),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .rdata_o    (rdata_o),
        .busErr_o   (busErr_o),
        .fwd_o      (fwd),
        .fwdValid_o (fwdValid),
        .mgrDone_i  (mgrDone),
        .mgrRsp_i   (mgrRsp)
    );

    wbManager manager_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .fwd_i      (fwd),
        .fwdValid_i (fwdValid),
        .wb_o       (busReq),
        .wb_i       (busRsp),
        .mgrDone_o  (mgrDone),
        .mgrRsp_o   (mgrRsp)
    );

    wbDecoder #(
        .NumSlots (NumSlots)
    ) decoder_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .wb_i      (busReq),
        .wb_o      (busRsp),
        .slotReq_o (slotReq),
        .slotRsp_i (slotRsp)
    );

    // one SRAM bank per decoder slot
    for (genvar k = 0; k < NumSlots; k++) begin : gSram
        wbSram #(
            .SramWords (SramWords)
        ) sram_i (
            .clk     (clk),
            .reset_i (reset_i),
            .wb_i    (slotReq[k]),
            .wb_o    (slotRsp[k])
        );
    end

endmodule

/* dv/memSubsys_assert.sv */
`timescale 1ns/1ps

module memSubsys_assert (
    input logic clk,
    input logic reset_i,
    input logic done_i,
    input logic busy_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic err_i
);

    // number of failed checks in this instance
    int unsigned assertFails = 0;

    doneOneCycle: assert property (@(posedge clk) disable iff (reset_i) done_i |=> !done_i)
        else begin
            $error("done pulse wider than one cycle");
            assertFails++;
        end

    busyLowAfterReset: assert property (@(posedge clk) reset_i |=> !busy_i)
        else begin
            $error("busy high right after reset");
            assertFails++;
        end

    stbNeedsCyc: assert property (@(posedge clk) disable iff (reset_i) stb_i |-> cyc_i)
        else begin
            $error("stb high without cyc");
            assertFails++;
        end

    // classic cycle drops one cycle after termination
    cycleEnds: assert property (@(posedge clk) disable iff (reset_i)
        (cyc_i && (ack_i || err_i)) |=> !cyc_i)
        else begin
            $error("wishbone cycle still open after ack or err");
            assertFails++;
        end

endmodule

bind mmioRouter memSubsys_assert routerChecks (
    .clk(clk), .reset_i(reset_i), .done_i(done_o), .busy_i(busy_o),
    .cyc_i(1'b0), .stb_i(1'b0), .ack_i(1'b0), .err_i(1'b0)
);

bind wbManager memSubsys_assert managerChecks (
    .clk(clk), .reset_i(reset_i), .done_i(mgrDone_o), .busy_i(1'b0),
    .cyc_i(wb_o.cyc), .stb_i(wb_o.stb), .ack_i(wb_i.ack), .err_i(wb_i.err)
);

/* dv/memSubsysTb.sv */
`timescale 1ns/1ps

module memSubsysTb;

    localparam int ResetCycles = 16;
    // allowance per case, a bus access with gap needs about ten
    localparam int CaseCycles  = 20;

    typedef struct packed {
        memBusPkg::reqOp_e op;
        logic [31:0]       addr;
        logic [31:0]       wdata;
        logic [31:0]       rdata;
        logic              err;
    } testCase_t;

    logic clk;
    logic reset_i;
    memBusPkg::memReq_t req;
    logic busy;
    logic done;
    logic [31:0] rdata;
    logic busErr;

    string caseNames [$];
    testCase_t cases [$];
    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;
    bit casesLoaded = 1'b0;

    memSubsysTop #(
        .NumSlots  (2),
        .SramWords (256)
    ) dut_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .req_i    (req),
        .busy_o   (busy),
        .done_o   (done),
        .rdata_o  (rdata),
        .busErr_o (busErr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkValue(input string name, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected 0x%08h, actual 0x%08h",
                     name, what, expected, actual);
            errorCount++;
        end
    endtask

    // register window answers in one cycle, every other address goes over the bus
    function automatic int expectedLatency(input logic [31:0] addr);
        if (addr >= memBusPkg::RegBase && (addr - memBusPkg::RegBase) < 32) begin
            return 1;
        end
        return 4;
    endfunction

    task automatic loadCases();
        int fd;
        int fields;
        int errFlag;
        string line;
        string name;
        string opText;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expData;
        testCase_t tc;
        fd = $fopen("dv/memSubsysCases.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/memSubsysCases.txt, there is nothing to run");
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.substr(0, 0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%s %s %h %h %h %d",
                                 name, opText, addr, wdata, expData, errFlag);
                if (fields == 6) begin
                    tc.op    = (opText == "W") ? memBusPkg::OpWrite : memBusPkg::OpRead;
                    tc.addr  = addr;
                    tc.wdata = wdata;
                    tc.rdata = expData;
                    tc.err   = (errFlag != 0);
                    if (opText != "W" && opText != "R") begin
                        $display("case %s has an unknown operation %s", name, opText);
                        errorCount++;
                    end
                    cases.push_back(tc);
                    caseNames.push_back(name);
                end else if (fields > 0) begin
                    $display("cannot parse case line: %s", line);
                    errorCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runCase(input testCase_t tc, input string name);
        int startErrors;
        int latency;
        startErrors = errorCount;
        checkValue(name, "busy_o before request", 32'd0, 32'(busy));
        req.op    = tc.op;
        req.addr  = tc.addr;
        req.wdata = tc.wdata;
        req.sel   = 4'hF;
        @(negedge clk);
        // accepted at the edge just passed, this write to the same word must be dropped
        checkValue(name, "busy_o after accept", 32'd1, 32'(busy));
        req.op    = memBusPkg::OpWrite;
        req.wdata = ~tc.wdata;
        latency   = 0;
        do begin
            @(negedge clk);
            latency++;
            req.op = memBusPkg::OpIdle;
        end while (!done && latency < CaseCycles);
        if (!done) begin
            $display("%s: done_o did not rise within %0d cycles", name, CaseCycles);
            errorCount++;
        end else begin
            checkValue(name, "latency", 32'(expectedLatency(tc.addr)), 32'(latency));
            if (tc.op == memBusPkg::OpRead) begin
                checkValue(name, "rdata_o", tc.rdata, rdata);
            end
            checkValue(name, "busErr_o", 32'(tc.err), 32'(busErr));
            @(negedge clk);
            checkValue(name, "busy_o after done", 32'd0, 32'(busy));
        end
        if (errorCount == startErrors) begin
            passCount++;
            $display("PASS %s", name);
        end else begin
            failCount++;
            $display("FAIL %s", name);
        end
    endtask

    initial begin
        int unsigned gap;
        int unsigned assertFails;
        void'($urandom(24590));
        req     = '0;
        reset_i = 1'b1;
        loadCases();
        casesLoaded = 1'b1;
        repeat (ResetCycles) @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);
        foreach (cases[i]) begin
            runCase(cases[i], caseNames[i]);
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
        end
        assertFails = dut_i.router_i.routerChecks.assertFails +
                      dut_i.manager_i.managerChecks.assertFails;
        if (assertFails != 0) begin
            $display("%0d assertion failures in the bound checkers", assertFails);
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0 && errorCount == 0 && assertFails == 0 && cases.size() > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog sized from the number of cases read
    initial begin
        int budget;
        wait (casesLoaded);
        budget = ResetCycles + CaseCycles * (cases.size() + 1);
        repeat (budget) @(posedge clk);
        $display("run timed out after %0d cycles, the DUT stopped answering", budget);
        $display("Something failed");
        $finish;
    end

endmodule

/* dv/memSubsysCases.txt */
# name op(W=write R=read) addr wdata expected-rdata(reads only) expected-busErr
# addresses and data in hex, error flag 0 or 1
regUnwritten     R FFFF0014 00000000 00000000 0
regWrite0        W FFFF0000 DEADBEEF 00000000 0
regRead0         R FFFF0000 00000000 DEADBEEF 0
regWrite7        W FFFF001C 12345678 00000000 0
regRead7         R FFFF001C 00000000 12345678 0
regMisaligned    R FFFF0003 00000000 DEADBEEF 0
regStillZero     R FFFF0014 00000000 00000000 0
slot0Write       W 00000010 11223344 00000000 0
slot1Write       W 00001010 55667788 00000000 0
slot0Read        R 00000010 00000000 11223344 0
slot1Read        R 00001010 00000000 55667788 0
slot0WrapWrite   W 00000420 A5A50001 00000000 0
slot0WrapRead    R 00000020 00000000 A5A50001 0
slot0AliasRead   R 00000420 00000000 A5A50001 0
slot1WrapWrite   W 00001440 CAFE0001 00000000 0
slot1WrapRead    R 00001040 00000000 CAFE0001 0
unmappedWrite    W 00002000 00000001 00000000 1
unmappedRead     R 00002000 00000000 00000000 1
unmappedHigh     R 7FFF0000 00000000 00000000 1
unmappedBelowReg R FFFEFFFC 00000000 00000000 1
slot0Recheck     R 00000010 00000000 11223344 0
slot1Recheck     R 00001010 00000000 55667788 0

/* build.f */
verilog/memBusPkg.sv
verilog/wbSram.sv
verilog/wbDecoder.sv
verilog/wbManager.sv
verilog/mmioRouter.sv
verilog/memSubsysTop.sv
dv/memSubsys_assert.sv
dv/memSubsysTb.sv

/* Bender.yml */
package:
  name: memSubsys

sources:
  - verilog/memBusPkg.sv
  - verilog/wbSram.sv
  - verilog/wbDecoder.sv
  - verilog/wbManager.sv
  - verilog/mmioRouter.sv
  - verilog/memSubsysTop.sv
  - target: test
    files:
      - dv/memSubsys_assert.sv
      - dv/memSubsysTb.sv
